// ==== Makefile ====
# Verilator build and run of the CSR slice testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := csr_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log is searched because a fatal stop does not survive the pipe
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/exu_csr_unit.sv
rtl/csr_regfile.sv
rtl/csr_writeback.sv
rtl/csr_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/csr_tb.sv

// ==== rtl/csr_decode.sv ====
// Zicsr field decode, purely combinational
// funct3 of 0 or 4 is not a CSR op and gives no request
module csr_decode (
    input  logic              instr_valid_i,
    input  csr_pkg::instr_t   instr_i,
    input  csr_pkg::xlen_t    rs1_data_i,

    output logic              req_csr_o,
    output logic              csrrw_o,
    output logic              csrrs_o,
    output logic              csrrc_o,
    output csr_pkg::xlen_t    csr_op1_o,
    output csr_pkg::csr_addr_t csr_addr_o,
    output csr_pkg::reg_idx_t rd_idx_o,
    output logic              rd_intent_o,
    output logic              ro_write_o
);
    import csr_pkg::*;

    // raw instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1_field;
    reg_idx_t   rd_field;
    csr_addr_t  addr_field;

    // internal intents
    logic       is_system;
    logic       is_csr_funct;
    logic       use_imm;
    logic       wr_intent;

    assign opcode     = instr_i[6:0];
    assign rd_field   = instr_i[11:7];
    assign funct3     = instr_i[14:12];
    // rs1 index, or uimm for the immediate forms
    assign rs1_field  = instr_i[19:15];
    assign addr_field = instr_i[31:20];

    assign is_system = (opcode == OPC_SYSTEM);

    // 0 is ecall/ebreak/mret space, 4 is reserved
    assign is_csr_funct = (funct3[1:0] != 2'b00);

    assign req_csr_o = instr_valid_i && is_system && is_csr_funct;

    // low two bits pick the op, bit 2 picks immediate
    assign csrrw_o = req_csr_o && (funct3[1:0] == 2'b01);
    assign csrrs_o = req_csr_o && (funct3[1:0] == 2'b10);
    assign csrrc_o = req_csr_o && (funct3[1:0] == 2'b11);

    assign use_imm = funct3[2];

    // uimm is zero-extended to a full word
    always_comb begin
        if (use_imm) begin
            csr_op1_o = xlen_t'(rs1_field);
        end else begin
            csr_op1_o = rs1_data_i;
        end
    end

    assign csr_addr_o = addr_field;
    assign rd_idx_o   = rd_field;

    // x0 destination means no register write
    assign rd_intent_o = (rd_field != '0);

    // rs/rc with x0 or uimm 0 is a pure read
    assign wr_intent = csrrw_o || ((csrrs_o || csrrc_o) && (rs1_field != '0));

    // top two address bits 11 mark a read-only CSR
    assign ro_write_o = wr_intent && (addr_field[11:10] == 2'b11);

endmodule

// ==== rtl/csr_pkg.sv ====
// shared types and constants for the machine-mode CSR slice
// only machine-level CSRs of a single hart are described here
package csr_pkg;

    // data word for registers and CSRs
    typedef logic [31:0] xlen_t;

    // CSR address field of a Zicsr instruction
    typedef logic [11:0] csr_addr_t;

    // integer register index
    typedef logic [4:0] reg_idx_t;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // SYSTEM major opcode
    localparam logic [6:0] OPC_SYSTEM = 7'h73;

    // implemented machine CSRs
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    // read-only, bits 11:10 are 2'b11
    localparam csr_addr_t CSR_CYCLE    = 12'hC00;
    localparam csr_addr_t CSR_MHARTID  = 12'hF14;

    // mstatus: only MIE (bit 3) and MPIE (bit 7)
    localparam xlen_t MSTATUS_WMASK = 32'h0000_0088;

    // mie: MSIE, MTIE, MEIE
    localparam xlen_t MIE_WMASK = 32'h0000_0888;

    // direct mode only, base is word aligned
    localparam xlen_t MTVEC_WMASK = 32'hFFFF_FFFC;

    // no compressed instructions, so mepc is word aligned
    localparam xlen_t MEPC_WMASK = 32'hFFFF_FFFC;

endpackage

// ==== rtl/csr_regfile.sv ====
// machine CSR storage, writes commit at the clock edge of the request
// cycle and mhartid are read-only and ignore csr_we_i
module csr_regfile #(
    parameter csr_pkg::xlen_t HART_ID     = '0,
    parameter csr_pkg::xlen_t MTVEC_RESET = '0
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               csr_we_i,
    input  csr_pkg::csr_addr_t csr_addr_i,
    input  csr_pkg::xlen_t     csr_wdata_i,

    output csr_pkg::xlen_t     csr_rdata_o,
    output logic               addr_hit_o
);
    import csr_pkg::*;

    // stored CSRs
    xlen_t mstatus_q;
    xlen_t mie_q;
    xlen_t mtvec_q;
    xlen_t mscratch_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t cycle_q;

    // masked bits take the new value, the rest stay put
    function automatic xlen_t apply_mask(xlen_t old_val, xlen_t new_val, xlen_t mask);
        apply_mask = (new_val & mask) | (old_val & ~mask);
    endfunction

    // read decode
    always_comb begin
        csr_rdata_o = '0;
        addr_hit_o  = 1'b1;
        case (csr_addr_i)
            CSR_MSTATUS:  csr_rdata_o = mstatus_q;
            CSR_MIE:      csr_rdata_o = mie_q;
            CSR_MTVEC:    csr_rdata_o = mtvec_q;
            CSR_MSCRATCH: csr_rdata_o = mscratch_q;
            CSR_MEPC:     csr_rdata_o = mepc_q;
            CSR_MCAUSE:   csr_rdata_o = mcause_q;
            CSR_CYCLE:    csr_rdata_o = cycle_q;
            CSR_MHARTID:  csr_rdata_o = HART_ID;
            default: begin
                // not implemented
                addr_hit_o = 1'b0;
            end
        endcase
    end

    // writable CSRs
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= MTVEC_RESET;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (csr_we_i) begin
            case (csr_addr_i)
                CSR_MSTATUS: begin
                    mstatus_q <= apply_mask(mstatus_q, csr_wdata_i, MSTATUS_WMASK);
                end
                CSR_MIE: begin
                    mie_q <= apply_mask(mie_q, csr_wdata_i, MIE_WMASK);
                end
                CSR_MTVEC: begin
                    // low bits forced to zero
                    mtvec_q <= csr_wdata_i & MTVEC_WMASK;
                end
                CSR_MSCRATCH: begin
                    mscratch_q <= csr_wdata_i;
                end
                CSR_MEPC: begin
                    mepc_q <= csr_wdata_i & MEPC_WMASK;
                end
                CSR_MCAUSE: begin
                    mcause_q <= csr_wdata_i;
                end
                default: begin
                    // read-only or unmapped, nothing stored
                end
            endcase
        end
    end

    // free-running cycle counter, wraps at 2^32
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 32'd1;
        end
    end

endmodule

// ==== rtl/csr_subsys_top.sv ====
// CSR slice top: decode, execute, CSR file and write-back stage
// one instruction per cycle, result one cycle later, no back-pressure
module csr_subsys_top #(
    parameter csr_pkg::xlen_t HART_ID     = '0,
    parameter csr_pkg::xlen_t MTVEC_RESET = '0
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              instr_valid_i,
    input  csr_pkg::instr_t   instr_i,
    input  csr_pkg::xlen_t    rs1_data_i,
    input  logic              int_assert_i,

    output logic              rd_we_o,
    output csr_pkg::reg_idx_t rd_addr_o,
    output csr_pkg::xlen_t    rd_wdata_o,
    output logic              illegal_o
);
    import csr_pkg::*;

    // decode to execute
    logic      req_csr;
    logic      csrrw;
    logic      csrrs;
    logic      csrrc;
    xlen_t     csr_op1;
    csr_addr_t csr_addr;
    reg_idx_t  rd_idx;
    logic      rd_intent;
    logic      ro_write;

    // CSR file lookup
    xlen_t     csr_rdata;
    logic      addr_hit;

    // execute outputs
    logic      csr_we;
    xlen_t     csr_wdata;
    logic      rd_we;
    xlen_t     reg_wdata;
    logic      illegal;

    csr_decode u_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .req_csr_o     (req_csr),
        .csrrw_o       (csrrw),
        .csrrs_o       (csrrs),
        .csrrc_o       (csrrc),
        .csr_op1_o     (csr_op1),
        .csr_addr_o    (csr_addr),
        .rd_idx_o      (rd_idx),
        .rd_intent_o   (rd_intent),
        .ro_write_o    (ro_write)
    );

    exu_csr_unit u_exu (
        .req_csr_i    (req_csr),
        .csrrw_i      (csrrw),
        .csrrs_i      (csrrs),
        .csrrc_i      (csrrc),
        .rd_intent_i  (rd_intent),
        .ro_write_i   (ro_write),
        .addr_hit_i   (addr_hit),
        .int_assert_i (int_assert_i),
        .csr_op1_i    (csr_op1),
        .csr_rdata_i  (csr_rdata),
        .csr_we_o     (csr_we),
        .rd_we_o      (rd_we),
        .illegal_o    (illegal),
        .csr_wdata_o  (csr_wdata),
        .reg_wdata_o  (reg_wdata)
    );

    // read is combinational, write lands at the next edge
    csr_regfile #(
        .HART_ID     (HART_ID),
        .MTVEC_RESET (MTVEC_RESET)
    ) u_regfile (
        .clk         (clk),
        .reset_i     (reset_i),
        .csr_we_i    (csr_we),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .csr_rdata_o (csr_rdata),
        .addr_hit_o  (addr_hit)
    );

    csr_writeback u_wb (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd_we_i    (rd_we),
        .illegal_i  (illegal),
        .rd_idx_i   (rd_idx),
        .rd_wdata_i (reg_wdata),
        .rd_we_o    (rd_we_o),
        .illegal_o  (illegal_o),
        .rd_addr_o  (rd_addr_o),
        .rd_wdata_o (rd_wdata_o)
    );

endmodule

// ==== rtl/csr_writeback.sv ====
// result stage, one register between execute and the write-back port
// address and data only update on a real register write
module csr_writeback (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              rd_we_i,
    input  logic              illegal_i,
    input  csr_pkg::reg_idx_t rd_idx_i,
    input  csr_pkg::xlen_t    rd_wdata_i,

    output logic              rd_we_o,
    output logic              illegal_o,
    output csr_pkg::reg_idx_t rd_addr_o,
    output csr_pkg::xlen_t    rd_wdata_o
);

    // strobes, one cycle each
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_we_o   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            rd_we_o   <= rd_we_i;
            illegal_o <= illegal_i;
        end
    end

    // payload holds between writes
    always_ff @(posedge clk) begin
        if (rd_we_i) begin
            rd_addr_o  <= rd_idx_i;
            rd_wdata_o <= rd_wdata_i;
        end
    end

endmodule

// ==== rtl/exu_csr_unit.sv ====
// CSR execute: new CSR value and old value returned as register data
// int_assert_i cancels the instruction completely, no illegal flag either
module exu_csr_unit (
    input  logic           req_csr_i,
    input  logic           csrrw_i,
    input  logic           csrrs_i,
    input  logic           csrrc_i,
    input  logic           rd_intent_i,
    input  logic           ro_write_i,
    input  logic           addr_hit_i,
    input  logic           int_assert_i,
    input  csr_pkg::xlen_t csr_op1_i,
    input  csr_pkg::xlen_t csr_rdata_i,

    output logic           csr_we_o,
    output logic           rd_we_o,
    output logic           illegal_o,
    output csr_pkg::xlen_t csr_wdata_o,
    output csr_pkg::xlen_t reg_wdata_o
);

    // request that survives interrupt gating
    logic active;

    assign active = req_csr_i && !int_assert_i;

    // unknown address or write to read-only space
    assign illegal_o = active && (!addr_hit_i || ro_write_i);

    // pure reads write the old value back, harmless
    assign csr_we_o = active && !illegal_o;
    assign rd_we_o  = csr_we_o && rd_intent_i;

    always_comb begin
        csr_wdata_o = '0;
        reg_wdata_o = '0;
        if (csr_we_o) begin
            // every CSR op returns the old value
            reg_wdata_o = csr_rdata_i;
            if (csrrw_i) begin
                csr_wdata_o = csr_op1_i;
            end else if (csrrs_i) begin
                // set bits
                csr_wdata_o = csr_rdata_i | csr_op1_i;
            end else if (csrrc_i) begin
                // clear bits
                csr_wdata_o = csr_rdata_i & ~csr_op1_i;
            end
        end
    end

endmodule

// ==== testbench/csr_tb.sv ====
// directed tests for the CSR slice against a small CSR model
// random operands come from a seeded LFSR
module csr_tb;

    localparam logic [31:0] HART_ID     = 32'h0000_0005;
    localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;
    localparam int          TIMEOUT     = 20;
    localparam logic [6:0]  OPC_SYSTEM  = 7'h73;

    // machine CSR addresses
    localparam logic [11:0] A_MSTATUS  = 12'h300;
    localparam logic [11:0] A_MIE      = 12'h304;
    localparam logic [11:0] A_MTVEC    = 12'h305;
    localparam logic [11:0] A_MSCRATCH = 12'h340;
    localparam logic [11:0] A_MEPC     = 12'h341;
    localparam logic [11:0] A_MCAUSE   = 12'h342;
    localparam logic [11:0] A_CYCLE    = 12'hC00;
    localparam logic [11:0] A_MHARTID  = 12'hF14;
    localparam logic [11:0] A_UNMAPPED = 12'h7C0;

    // funct3 of the six Zicsr ops
    localparam logic [2:0] F_RW  = 3'b001;
    localparam logic [2:0] F_RS  = 3'b010;
    localparam logic [2:0] F_RC  = 3'b011;
    localparam logic [2:0] F_RWI = 3'b101;
    localparam logic [2:0] F_RSI = 3'b110;
    localparam logic [2:0] F_RCI = 3'b111;

    logic        clk;
    logic        reset_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] rs1_data_i;
    logic        int_assert_i;
    logic        rd_we_o;
    logic [4:0]  rd_addr_o;
    logic [31:0] rd_wdata_o;
    logic        illegal_o;

    // CSR model
    logic [31:0] m_mstatus;
    logic [31:0] m_mie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;

    // operand generator state
    logic [31:0] lfsr_state;

    tb_clock_gen u_clk (
        .clk_o (clk)
    );

    csr_subsys_top #(
        .HART_ID     (HART_ID),
        .MTVEC_RESET (MTVEC_RESET)
    ) UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .int_assert_i  (int_assert_i),
        .rd_we_o       (rd_we_o),
        .rd_addr_o     (rd_addr_o),
        .rd_wdata_o    (rd_wdata_o),
        .illegal_o     (illegal_o)
    );

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // replace, set or clear on the old value
    function automatic logic [31:0] next_value(input logic [1:0] op, input logic [31:0] old_val,
                                               input logic [31:0] op1);
        case (op)
            2'b01:   return op1;
            2'b10:   return old_val | op1;
            2'b11:   return old_val & ~op1;
            default: return old_val;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            A_MSTATUS:  return m_mstatus;
            A_MIE:      return m_mie;
            A_MTVEC:    return m_mtvec;
            A_MSCRATCH: return m_mscratch;
            A_MEPC:     return m_mepc;
            A_MCAUSE:   return m_mcause;
            A_MHARTID:  return HART_ID;
            default:    return 32'h0;
        endcase
    endfunction

    // masked bits take the new value and the rest keep the old one
    task automatic model_write(input logic [11:0] addr, input logic [31:0] nv);
        case (addr)
            A_MSTATUS:  m_mstatus = (nv & 32'h0000_0088) | (m_mstatus & ~32'h0000_0088);
            A_MIE:      m_mie = (nv & 32'h0000_0888) | (m_mie & ~32'h0000_0888);
            A_MTVEC:    m_mtvec = nv & 32'hFFFF_FFFC;
            A_MSCRATCH: m_mscratch = nv;
            A_MEPC:     m_mepc = nv & 32'hFFFF_FFFC;
            A_MCAUSE:   m_mcause = nv;
            default:    ;
        endcase
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            fail_run("value mismatch at the write-back port");
        end
    endtask

    task automatic issue_csr(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] rs1f,
                             input logic [4:0] rd, input logic [31:0] data);
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= {addr, rs1f, f3, rd, OPC_SYSTEM};
        rs1_data_i    <= data;
    endtask

    task automatic stop_issue;
        @(posedge clk);
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        rs1_data_i    <= '0;
    endtask

    // single instruction valid for one cycle
    task automatic run_csr(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] rs1f,
                           input logic [4:0] rd, input logic [31:0] data);
        issue_csr(f3, addr, rs1f, rd, data);
        stop_issue();
    endtask

    // sample on the falling edge away from the driving edge
    task automatic wait_strobe;
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            seen = rd_we_o || illegal_o;
            n++;
        end
        if (!seen) begin
            fail_run("timeout while waiting for a write-back or illegal strobe");
        end
    endtask

    task automatic expect_wb(input logic exp_illegal, input logic [4:0] exp_rd,
                             input logic [31:0] exp_data);
        wait_strobe();
        if (exp_illegal) begin
            check_val("illegal_o", 32'(illegal_o), 32'h1);
            check_val("rd_we_o", 32'(rd_we_o), 32'h0);
        end else begin
            check_val("rd_we_o", 32'(rd_we_o), 32'h1);
            check_val("illegal_o", 32'(illegal_o), 32'h0);
            check_val("rd_addr_o", 32'(rd_addr_o), 32'(exp_rd));
            check_val("rd_wdata_o", rd_wdata_o, exp_data);
        end
    endtask

    // legal op with rd not x0 checks the old value and updates the model
    task automatic csr_op(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] rs1f,
                          input logic [4:0] rd, input logic [31:0] data);
        logic [31:0] old_val;
        logic [31:0] op1;
        old_val = model_read(addr);
        op1     = f3[2] ? {27'd0, rs1f} : data;
        run_csr(f3, addr, rs1f, rd, data);
        expect_wb(1'b0, rd, old_val);
        model_write(addr, next_value(f3[1:0], old_val, op1));
    endtask

    task automatic expect_illegal(input logic [2:0] f3, input logic [11:0] addr,
                                  input logic [4:0] rs1f, input logic [31:0] data);
        run_csr(f3, addr, rs1f, 5'd9, data);
        expect_wb(1'b1, 5'd0, 32'h0);
    endtask

    task automatic read_cycle(output logic [31:0] val);
        run_csr(F_RS, A_CYCLE, 5'd0, 5'd10, 32'h0);
        wait_strobe();
        check_val("rd_we_o", 32'(rd_we_o), 32'h1);
        check_val("illegal_o", 32'(illegal_o), 32'h0);
        val = rd_wdata_o;
    endtask

    task automatic test_reset_values;
        @(negedge clk);
        check_val("rd_we_o", 32'(rd_we_o), 32'h0);
        check_val("illegal_o", 32'(illegal_o), 32'h0);
        csr_op(F_RS, A_MSTATUS, 5'd0, 5'd1, 32'h0);
        csr_op(F_RS, A_MSCRATCH, 5'd0, 5'd1, 32'h0);
        csr_op(F_RS, A_MTVEC, 5'd0, 5'd1, 32'h0);
        csr_op(F_RS, A_MHARTID, 5'd0, 5'd1, 32'h0);
    endtask

    task automatic test_reg_forms;
        logic [11:0] addr;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 2; j++) begin
                addr = (j == 0) ? A_MSCRATCH : A_MEPC;
                csr_op(F_RW, addr, 5'd2, 5'd3, rand_bits(32));
                csr_op(F_RS, addr, 5'd2, 5'd4, rand_bits(32));
                csr_op(F_RC, addr, 5'd2, 5'd5, rand_bits(32));
                csr_op(F_RS, addr, 5'd0, 5'd6, 32'h0);
            end
        end
        // mtvec drops the low two bits
        csr_op(F_RW, A_MTVEC, 5'd1, 5'd2, 32'h0000_2003);
        csr_op(F_RS, A_MTVEC, 5'd0, 5'd2, 32'h0);
    endtask

    task automatic test_imm_forms;
        logic [11:0] addr;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 2; j++) begin
                addr = (j == 0) ? A_MSTATUS : A_MIE;
                csr_op(F_RWI, addr, 5'(rand_bits(5)), 5'd7, 32'h0);
                csr_op(F_RSI, addr, 5'(rand_bits(5)), 5'd8, 32'h0);
                csr_op(F_RCI, addr, 5'(rand_bits(5)), 5'd9, 32'h0);
                // zero uimm is a pure read
                csr_op(F_RSI, addr, 5'd0, 5'd10, 32'h0);
                csr_op(F_RCI, addr, 5'd0, 5'd11, 32'h0);
                csr_op(F_RW, addr, 5'd1, 5'd12, 32'hFFFF_FFFF);
                csr_op(F_RS, addr, 5'd0, 5'd13, 32'h0);
            end
        end
    endtask

    task automatic test_illegal;
        logic [31:0] c0;
        logic [31:0] c1;
        logic [31:0] c2;
        read_cycle(c0);
        expect_illegal(F_RW, A_CYCLE, 5'd1, 32'hFFFF_FF00);
        expect_illegal(F_RSI, A_CYCLE, 5'd4, 32'h0);
        read_cycle(c1);
        expect_illegal(F_RW, A_MHARTID, 5'd1, 32'hDEAD_BEEF);
        csr_op(F_RS, A_MHARTID, 5'd0, 5'd1, 32'h0);
        expect_illegal(F_RW, A_UNMAPPED, 5'd1, rand_bits(32));
        expect_illegal(F_RS, A_UNMAPPED, 5'd0, 32'h0);
        csr_op(F_RS, A_MSCRATCH, 5'd0, 5'd1, 32'h0);
        repeat (3) @(posedge clk);
        read_cycle(c2);
        if (!(c0 < c1 && c1 < c2)) begin
            fail_run("cycle reads are not strictly increasing");
        end
        if (c1 >= 32'h0000_1000) begin
            fail_run("cycle counter took the value of an illegal write");
        end
    endtask

    // cancelled op has its result slot one cycle after issue
    task automatic test_int_assert;
        logic [11:0] addr;
        for (int j = 0; j < 2; j++) begin
            addr = (j == 0) ? A_MSCRATCH : A_UNMAPPED;
            @(posedge clk);
            int_assert_i <= 1'b1;
            run_csr(F_RW, addr, 5'd1, 5'd14, rand_bits(32));
            @(negedge clk);
            check_val("rd_we_o", 32'(rd_we_o), 32'h0);
            check_val("illegal_o", 32'(illegal_o), 32'h0);
            @(posedge clk);
            int_assert_i <= 1'b0;
        end
        csr_op(F_RS, A_MSCRATCH, 5'd0, 5'd1, 32'h0);
    endtask

    task automatic test_back_to_back;
        logic [31:0] v;
        logic [31:0] old_val;
        // write with rd = x0 and read at once
        v = rand_bits(32);
        issue_csr(F_RW, A_MSCRATCH, 5'd1, 5'd0, v);
        issue_csr(F_RS, A_MSCRATCH, 5'd0, 5'd15, 32'h0);
        @(negedge clk);
        check_val("rd_we_o", 32'(rd_we_o), 32'h0);
        check_val("illegal_o", 32'(illegal_o), 32'h0);
        stop_issue();
        model_write(A_MSCRATCH, v);
        expect_wb(1'b0, 5'd15, m_mscratch);
        // both with a destination
        v       = rand_bits(32);
        old_val = model_read(A_MEPC);
        issue_csr(F_RW, A_MEPC, 5'd1, 5'd16, v);
        issue_csr(F_RS, A_MEPC, 5'd0, 5'd17, 32'h0);
        expect_wb(1'b0, 5'd16, old_val);
        stop_issue();
        model_write(A_MEPC, v);
        expect_wb(1'b0, 5'd17, m_mepc);
    endtask

    initial begin
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_data_i    = '0;
        int_assert_i  = 1'b0;
        lfsr_state    = 32'h5feaacf0;
        m_mstatus     = '0;
        m_mie         = '0;
        m_mtvec       = MTVEC_RESET;
        m_mscratch    = '0;
        m_mepc        = '0;
        m_mcause      = '0;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        test_reset_values();
        test_reg_forms();
        test_imm_forms();
        test_illegal();
        test_int_assert();
        test_back_to_back();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
// free-running testbench clock, starts low at time zero
// default period is 4 time units
module tb_clock_gen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // toggle every half period
    always begin
        #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule
